//--- Bender.yml
package:
  name: fetch_subsystem

sources:
  # Packages first, then the design from the leaves up
  - logic/mem_bus_pkg.sv
  - logic/icache_pkg.sv
  - logic/icache.sv
  - logic/mem_issue.sv
  - logic/mem_slot.sv
  - logic/mem_return.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_tb.sv

//--- compile.f
logic/mem_bus_pkg.sv
logic/icache_pkg.sv
logic/icache.sv
logic/mem_issue.sv
logic/mem_slot.sv
logic/mem_return.sv
logic/fetch_top.sv
testbench/fetch_tb.sv

//--- logic/fetch_top.sv
`timescale 1ns/1ns

module fetch_top
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int NUM_LINES   = 8,
  parameter int MEM_LATENCY = 6
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [63:0] i_fetch_addr,
  output logic [63:0] o_inst,
  output logic        o_inst_valid
);

  bus_cmd_t                                   mem_command;
  logic [63:0]                                mem_addr;
  logic [MEM_TAG_BITS-1:0]                    mem_response;
  logic [63:0]                                mem_data;
  logic [MEM_TAG_BITS-1:0]                    mem_tag;
  logic [NUM_MEM_TAGS-1:0]                    slot_start;
  logic [NUM_MEM_TAGS-1:0]                    slot_busy;
  logic [NUM_MEM_TAGS-1:0]                    slot_done;
  logic [ROM_ADDR_BITS-1:0]                   issue_word_addr;
  logic [NUM_MEM_TAGS-1:0][ROM_ADDR_BITS-1:0] slot_addr;

  icache #(.NUM_LINES(NUM_LINES)) u_icache (
    .clock,
    .reset,
    .i_fetch_addr   (i_fetch_addr[ADDR_BITS-1:0]),
    .i_mem_response (mem_response),
    .i_mem_data     (mem_data),
    .i_mem_tag      (mem_tag),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .o_inst,
    .o_inst_valid
  );

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  mem_issue u_issue (
    .clock,
    .reset,
    .i_command   (mem_command),
    .i_addr      (mem_addr),
    .i_busy      (slot_busy),
    .o_response  (mem_response),
    .o_start     (slot_start),
    .o_word_addr (issue_word_addr)
  );

  for (genvar i = 0; i < NUM_MEM_TAGS; i++) begin : g_slot
    mem_slot #(.MEM_LATENCY(MEM_LATENCY)) u_slot (
      .clock,
      .reset,
      .i_start     (slot_start[i]),
      .i_word_addr (issue_word_addr),
      .o_busy      (slot_busy[i]),
      .o_done      (slot_done[i]),
      .o_word_addr (slot_addr[i])
    );
  end

  mem_return u_return (
    .clock,
    .reset,
    .i_done      (slot_done),
    .i_slot_addr (slot_addr),
    .o_data      (mem_data),
    .o_tag       (mem_tag)
  );

endmodule

//--- logic/icache.sv
`timescale 1ns/1ns

module icache
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int NUM_LINES = 8
) (
  input  logic                    clock,
  input  logic                    reset,
  input  fetch_addr_t             i_fetch_addr,
  input  logic [MEM_TAG_BITS-1:0] i_mem_response,
  input  logic [63:0]             i_mem_data,
  input  logic [MEM_TAG_BITS-1:0] i_mem_tag,
  output bus_cmd_t                o_mem_command,
  output logic [63:0]             o_mem_addr,
  output logic [63:0]             o_inst,
  output logic                    o_inst_valid
);

  logic                     line_valid [NUM_LINES];
  logic [LINE_TAG_BITS-1:0] line_tag   [NUM_LINES];
  logic [63:0]              line_data  [NUM_LINES];

  // Bus tag to line, for matching returns
  logic [LINE_IDX_BITS-1:0] tt_idx [2**MEM_TAG_BITS];
  logic [LINE_TAG_BITS-1:0] tt_tag [2**MEM_TAG_BITS];

  logic [LINE_IDX_BITS-1:0] idx, head, tail, new_head;
  logic [LINE_IDX_BITS-1:0] idx_dist, tail_dist;
  logic [LINE_IDX_BITS-1:0] adv_idx, fill_idx;
  logic [LINE_TAG_BITS-1:0] tag, adv_tag;
  logic                     in_window, tag_match, hit;
  logic                     accepted, advance, fill;
  fetch_addr_t              req_addr;

  // ----------------------------------------
  // Lookup
  // ----------------------------------------
  assign idx = i_fetch_addr.line.idx;
  assign tag = i_fetch_addr.line.tag;

  assign idx_dist  = idx - head;
  assign tail_dist = tail - head;
  assign in_window = idx_dist <= tail_dist;
  assign tag_match = line_tag[idx] == tag;
  assign hit       = in_window && tag_match;

  assign o_inst       = line_data[idx];
  assign o_inst_valid = line_valid[idx] && tag_match;

  // ----------------------------------------
  // Request
  // ----------------------------------------
  // Prefetch the tail line, or go straight for the miss
  always_comb begin
    if (hit) begin
      req_addr.line = '{tag: line_tag[tail], idx: tail, offset: '0};
    end else begin
      req_addr.line = '{tag: tag, idx: idx, offset: '0};
    end
  end

  assign o_mem_addr = {{(64 - ADDR_BITS){1'b0}}, req_addr.word};

  assign new_head = hit ? head : idx;
  assign adv_idx  = req_addr.line.idx + 1'b1;
  // Crossing the last index moves to the next tag
  assign adv_tag  = (adv_idx == '0) ? req_addr.line.tag + 1'b1 : req_addr.line.tag;
  assign accepted = i_mem_response != '0;
  assign advance  = accepted && (adv_idx != new_head);

  // Stale returns fail the tag check
  assign fill_idx = tt_idx[i_mem_tag];
  assign fill     = (i_mem_tag != '0) && (line_tag[fill_idx] == tt_tag[i_mem_tag]);

  // ----------------------------------------
  // Window and line state
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      head          <= '0;
      tail          <= '0;
      o_mem_command <= BUS_NONE;
      for (int i = 0; i < NUM_LINES; i++) begin
        line_valid[i] <= 1'b0;
        line_tag[i]   <= '0;
      end
    end else begin
      o_mem_command <= BUS_LOAD;
      if (fill) begin
        line_valid[fill_idx] <= 1'b1;
      end
      if (!hit) begin
        head <= idx;
        tail <= idx;
        if (!tag_match) begin
          line_tag[idx]   <= tag;
          line_valid[idx] <= 1'b0;
        end
      end
      // Open the next line behind the one just requested
      if (advance) begin
        tail <= adv_idx;
        if (line_tag[adv_idx] != adv_tag) begin
          line_tag[adv_idx]   <= adv_tag;
          line_valid[adv_idx] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      line_data[fill_idx] <= i_mem_data;
    end
    if (accepted) begin
      tt_idx[i_mem_response] <= req_addr.line.idx;
      tt_tag[i_mem_response] <= req_addr.line.tag;
    end
  end

  // Line count must agree with the address split
  assert property (@(posedge clock) NUM_LINES == (1 << LINE_IDX_BITS))
    else $error("NUM_LINES %0d does not match LINE_IDX_BITS", NUM_LINES);

  assert property (@(posedge clock) disable iff (reset) o_mem_command != BUS_STORE);

endmodule

//--- logic/icache_pkg.sv
package icache_pkg;

  // Meaningful part of the fetch address
  localparam int ADDR_BITS = 16;

  localparam int OFFSET_BITS = 3;
  localparam int LINE_IDX_BITS = 3;
  localparam int LINE_TAG_BITS = ADDR_BITS - LINE_IDX_BITS - OFFSET_BITS;

  // ----------------------------------------
  // Fetch address views
  // ----------------------------------------
  typedef struct packed {
    logic [LINE_TAG_BITS-1:0] tag;
    logic [LINE_IDX_BITS-1:0] idx;
    logic [OFFSET_BITS-1:0]   offset;
  } line_addr_t;

  // Raw word for the bus, fields for the cache lookup
  typedef union packed {
    logic [ADDR_BITS-1:0] word;
    line_addr_t           line;
  } fetch_addr_t;

endpackage

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

  // ----------------------------------------
  // Bus commands
  // ----------------------------------------
  typedef enum logic [1:0] {
    BUS_NONE  = 2'b00,
    BUS_LOAD  = 2'b01,
    BUS_STORE = 2'b10
  } bus_cmd_t;

  // Tag 0 is reserved for no transaction
  localparam int MEM_TAG_BITS = 4;
  localparam int NUM_MEM_TAGS = 15;

  // ----------------------------------------
  // Instruction ROM
  // ----------------------------------------
  localparam int ROM_WORDS = 32;
  // Word address taken from byte address bits 7 to 3
  localparam int ROM_ADDR_BITS = $clog2(ROM_WORDS);
  localparam string ROM_FILE = "rom.hex";

endpackage

//--- logic/mem_issue.sv
`timescale 1ns/1ns

module mem_issue
  import mem_bus_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  bus_cmd_t                 i_command,
  input  logic [63:0]              i_addr,
  input  logic [NUM_MEM_TAGS-1:0]  i_busy,
  output logic [MEM_TAG_BITS-1:0]  o_response,
  output logic [NUM_MEM_TAGS-1:0]  o_start,
  output logic [ROM_ADDR_BITS-1:0] o_word_addr
);

  // Lowest free slot wins, tag is slot number plus one
  always_comb begin
    o_response = '0;
    o_start    = '0;
    if (i_command == BUS_LOAD) begin
      for (int i = NUM_MEM_TAGS - 1; i >= 0; i--) begin
        if (!i_busy[i]) begin
          o_response = MEM_TAG_BITS'(i + 1);
          o_start    = NUM_MEM_TAGS'(1) << i;
        end
      end
    end
  end

  assign o_word_addr = i_addr[ROM_ADDR_BITS+2:3];

  // All busy means refused
  assert property (@(posedge clock) disable iff (reset) $onehot0(o_start));

endmodule

//--- logic/mem_return.sv
`timescale 1ns/1ns

module mem_return
  import mem_bus_pkg::*;
(
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic [NUM_MEM_TAGS-1:0]                     i_done,
  input  logic [NUM_MEM_TAGS-1:0][ROM_ADDR_BITS-1:0]  i_slot_addr,
  output logic [63:0]                                 o_data,
  output logic [MEM_TAG_BITS-1:0]                     o_tag
);

  logic [63:0]              rom [ROM_WORDS];
  logic [ROM_ADDR_BITS-1:0] sel_addr;

  initial begin
    $readmemh(ROM_FILE, rom);
  end

  // ----------------------------------------
  // Completed slot select
  // ----------------------------------------
  always_comb begin
    o_tag    = '0;
    sel_addr = '0;
    for (int i = 0; i < NUM_MEM_TAGS; i++) begin
      if (i_done[i]) begin
        o_tag    = MEM_TAG_BITS'(i + 1);
        sel_addr = i_slot_addr[i];
      end
    end
  end

  assign o_data = rom[sel_addr];

  // Fixed latency and one grant per cycle
  assert property (@(posedge clock) disable iff (reset) $onehot0(i_done));

endmodule

//--- logic/mem_slot.sv
`timescale 1ns/1ns

module mem_slot
  import mem_bus_pkg::*;
#(
  parameter int MEM_LATENCY = 6
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     i_start,
  input  logic [ROM_ADDR_BITS-1:0] i_word_addr,
  output logic                     o_busy,
  output logic                     o_done,
  output logic [ROM_ADDR_BITS-1:0] o_word_addr
);

  logic [$clog2(MEM_LATENCY+1)-1:0] count;

  // Last busy cycle carries the data
  assign o_done = o_busy && (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      o_busy <= 1'b0;
    end else if (i_start) begin
      o_busy <= 1'b1;
    end else if (o_done) begin
      o_busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (i_start) begin
      o_word_addr <= i_word_addr;
      count       <= ($clog2(MEM_LATENCY+1))'(MEM_LATENCY - 1);
    end else if (o_busy && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (reset) i_start |-> !o_busy);

endmodule

//--- rom.hex
// One 64-bit instruction word per line, word addresses 0 to 31
00a5051300000093
00b585b3fe010113
00113c2300813823
0400041300c12a23
fea42623fec42783
0017879bfef42623
fec42703000007b7
00e7d4630027071b
0007851b01813083
0101340302010113
00008067fd010113
02813423c2a1f00e
9b3d51e0047a6c15
3f8e20d7c44b1a92
e15a6b07d93c4f28
5c0d9e3a1b7f8246
a4e17c53098d2fb1
71b3c9e5f0264da8
0c58f2a7e913b46d
d6247b19a5c03e8f
48fa0e3c6b1d9572
b290d5f48e7a13c6
63e7a81d2c4fb059
f81c46b7035e9da2
1da5e3920f7c68b4
8746b0dcea135f29
2b9f174e60d8c3a5
c4d08a63b75e21f7
5e31f9c7248ad06b
9ac26e1583f74bd0
07b4d82fc69e1a35
e9f3254a1d80b76c

//--- testbench/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

  localparam int LAT       = 6;
  localparam int MISS_WAIT = 2 * LAT + 2;
  localparam int PREF_WAIT = LAT + 2;
  localparam int DWELL     = 20;
  localparam int NUM_TESTS = 7;
  // Worst case cycles of each test, in run order
  localparam int STIM_CYCLES = 2 + LAT
    + 3 * 8 * (MISS_WAIT + 2)
    + 16 * (MISS_WAIT + 2)
    + 24 * (MISS_WAIT + 1)
    + 3 * (MISS_WAIT + DWELL)
    + 3 * (MISS_WAIT + 2 + 4 * (PREF_WAIT + 2))
    + 16 + 6 * 2 * (MISS_WAIT + 2);
  localparam int CYCLE_LIMIT = STIM_CYCLES + 4 * LAT * NUM_TESTS;

  logic        clock;
  logic        reset;
  logic [63:0] fetch_addr;
  logic [63:0] inst;
  logic        inst_valid;

  logic [63:0] rom_model [32];
  integer      seed = 32'hcd14188c;
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;

  fetch_top #(.NUM_LINES(8), .MEM_LATENCY(LAT)) i_dut (
    .clock,
    .reset,
    .i_fetch_addr (fetch_addr),
    .o_inst       (inst),
    .o_inst_valid (inst_valid)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Model and helpers
  // ----------------------------------------
  // ROM word comes from byte address bits 7 to 3
  function automatic logic [63:0] expected_inst(input logic [63:0] addr);
    return rom_model[addr[7:3]];
  endfunction

  function automatic logic [15:0] random_addr();
    return 16'($random(seed));
  endfunction

  // Any valid word must match the model
  always @(negedge clock) begin
    if (!reset && inst_valid === 1'b1) begin
      check_count++;
      assert (inst === expected_inst(fetch_addr)) else begin
        error_count++;
        $display("ERROR %0t ns: o_inst expected %h actual %h at address %h",
                 $time, expected_inst(fetch_addr), inst, fetch_addr);
      end
    end
  end

  task automatic drive_addr(input logic [63:0] addr);
    @(posedge clock);
    #1;
    fetch_addr = addr;
  endtask

  task automatic hold(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  task automatic wait_valid(input int max_cycles, input string what);
    bit ok;
    ok = 1'b0;
    for (int n = 0; n < max_cycles && !ok; n++) begin
      @(negedge clock);
      ok = inst_valid === 1'b1;
    end
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("%0t ns: %s at address %h never completed within %0d cycles",
               $time, what, fetch_addr, max_cycles);
    end
  endtask

  task automatic expect_valid_bit(input logic value);
    check_count++;
    assert (inst_valid === value) else begin
      error_count++;
      $display("ERROR %0t ns: o_inst_valid expected %b actual %b", $time, value, inst_valid);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %-14s finished with %0d errors", name, error_count - errors_before);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic check_reset_state();
    int start;
    start = error_count;
    for (int k = 0; k < LAT; k++) begin
      if (k == 0) begin
        fetch_addr = {48'h0, random_addr()};
      end else begin
        drive_addr(random_addr());
      end
      @(negedge clock);
      expect_valid_bit(1'b0);
    end
    report_test("reset_state", start);
  endtask

  task automatic run_sequential();
    int          start;
    logic [15:0] addr;
    start = error_count;
    for (int r = 0; r < 3; r++) begin
      addr = random_addr();
      for (int s = 0; s < 8; s++) begin
        drive_addr(addr);
        wait_valid(MISS_WAIT, "sequential fetch");
        hold(2);
        addr = addr + 16'd8;
      end
    end
    report_test("sequential", start);
  endtask

  task automatic run_random_jumps();
    int start;
    start = error_count;
    for (int j = 0; j < 16; j++) begin
      drive_addr(random_addr());
      wait_valid(MISS_WAIT, "miss after a jump");
      hold(2);
    end
    report_test("random_jumps", start);
  endtask

  task automatic run_repeats();
    int          start;
    logic [15:0] pool [3];
    start = error_count;
    foreach (pool[i]) pool[i] = random_addr();
    for (int k = 0; k < 24; k++) begin
      drive_addr(pool[random_addr() % 3]);
      wait_valid(MISS_WAIT, "repeated fetch");
      hold(1);
    end
    report_test("repeats", start);
  endtask

  task automatic run_dwells();
    int start;
    start = error_count;
    for (int d = 0; d < 3; d++) begin
      drive_addr(random_addr());
      wait_valid(MISS_WAIT, "miss before a dwell");
      for (int c = 0; c < DWELL; c++) begin
        @(negedge clock);
        expect_valid_bit(1'b1);
      end
    end
    report_test("dwells", start);
  endtask

  // Lines behind a held address are already on their way
  task automatic run_prefetch();
    int          start;
    logic [15:0] base;
    start = error_count;
    for (int p = 0; p < 3; p++) begin
      base = random_addr();
      drive_addr(base);
      wait_valid(MISS_WAIT, "miss before prefetch");
      hold(2);
      for (int s = 1; s <= 4; s++) begin
        drive_addr(base + 16'(8 * s));
        wait_valid(PREF_WAIT, "prefetched line");
        hold(2);
      end
    end
    report_test("prefetch", start);
  endtask

  task automatic run_conflicts();
    int          start;
    logic [15:0] addr_a, addr_b, flip;
    logic [63:0] alias_addr;
    start = error_count;
    addr_a = random_addr();
    flip   = random_addr();
    // Same index and offset, line tag differs at least in bit 6
    addr_b = addr_a ^ {flip[9:0] | 10'd1, 6'd0};
    for (int k = 0; k < 16; k++) begin
      drive_addr(k[0] ? addr_b : addr_a);
    end
    for (int k = 0; k < 6; k++) begin
      drive_addr(addr_a);
      wait_valid(MISS_WAIT, "conflicting address");
      // Bits above the cache address alias onto the same line
      alias_addr = {32'($random(seed)), 16'($random(seed)), addr_a};
      drive_addr(alias_addr);
      @(negedge clock);
      check_count++;
      assert (inst_valid === 1'b1) else begin
        error_count++;
        $display("%0t ns: aliased address %h missed a loaded line", $time, alias_addr);
      end
      drive_addr(addr_b);
      wait_valid(MISS_WAIT, "conflicting address");
    end
    report_test("conflicts", start);
  endtask

  initial begin
    reset      = 1'b1;
    fetch_addr = '0;
    $readmemh("rom.hex", rom_model);
    check_count++;
    assert (!$isunknown(rom_model[31])) else begin
      error_count++;
      $display("The instruction model could not be loaded from rom.hex");
    end
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    run_sequential();
    run_random_jumps();
    run_repeats();
    run_dwells();
    run_prefetch();
    run_conflicts();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
